/* Bender.yml */
package:
  name: gpu_cmd

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - gpu_cmd_pkg.sv
      - spi_cmd_receiver.sv
      - command_fifo.sv
      - register_file.sv
      - gpu_cmd_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_gpu_cmd_top.sv

/* command_fifo.sv */
`include "gpu_cmd_params.svh"

module command_fifo (
    input  logic                    clk_core,
    input  logic                    rst_n,
    input  logic                    push,
    input  gpu_cmd_pkg::cmd_entry_t push_entry,
    input  logic                    pop,
    output gpu_cmd_pkg::cmd_entry_t head,
    output logic                    full,
    output logic                    almost_full,
    output logic                    empty
);

    import gpu_cmd_pkg::*;

    localparam int PTR_W = $clog2(`GPU_CMD_FIFO_DEPTH);
    localparam logic [`GPU_CMD_COUNT_W:0] DEPTH   = `GPU_CMD_FIFO_DEPTH;
    localparam logic [`GPU_CMD_COUNT_W:0] AF_MARK = `GPU_CMD_ALMOST_FULL;

    cmd_entry_t                mem [`GPU_CMD_FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [`GPU_CMD_COUNT_W:0] count;
    logic [`GPU_CMD_COUNT_W:0] count_nxt;

    // ========================================
    // Storage
    // ========================================

    // Full check lives in the receiver
    always_ff @(posedge clk_core) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    // Fall-through head, no output register
    assign head = mem[rd_ptr];

    // ========================================
    // Pointers and occupancy
    // ========================================

    // Push and pop together leave count alone
    always_comb begin
        case ({push, pop})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;
        endcase
    end

    always_ff @(posedge clk_core) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            // Power-of-two depth, pointers wrap on their own
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count       <= count_nxt;
            // Registered flag, in step with count
            almost_full <= (count_nxt >= AF_MARK);
        end
    end

    assign empty = (count == '0);
    assign full  = (count == DEPTH);

    // Consumer side owns the empty check
    a_no_pop_when_empty: assert property (
        @(posedge clk_core) disable iff (!rst_n) !(pop && empty)
    ) else $error("pop while command FIFO empty");

    a_count_bound: assert property (
        @(posedge clk_core) disable iff (!rst_n) count <= DEPTH
    ) else $error("command FIFO count above depth");

endmodule

/* gpu_cmd.f */
+incdir+.
gpu_cmd_pkg.sv
spi_cmd_receiver.sv
command_fifo.sv
register_file.sv
gpu_cmd_top.sv
tb_gpu_cmd_top.sv

/* gpu_cmd_params.svh */
`ifndef GPU_CMD_PARAMS_SVH
`define GPU_CMD_PARAMS_SVH

// ========================================
// SPI frame
// ========================================

// rw bit, 7-bit address, 64 data bits, MSB first
`define GPU_FRAME_BITS 72

// ========================================
// Command FIFO
// ========================================

`define GPU_CMD_FIFO_DEPTH 32
// Near-full warning raised at or above this count
`define GPU_CMD_ALMOST_FULL 30
`define GPU_CMD_COUNT_W 6

// ========================================
// Register map
// ========================================

`define GPU_REG_COLOR 7'h00
// Vertex writes, with and without triangle kick
`define GPU_REG_VERTEX_NOKICK 7'h06
`define GPU_REG_VERTEX_KICK 7'h07
`define GPU_REG_TRI_MODE 7'h30
`define GPU_REG_Z_RANGE 7'h31
`define GPU_REG_FB_DRAW 7'h40

`endif

/* gpu_cmd_pkg.sv */
package gpu_cmd_pkg;

    // ========================================
    // Command path
    // ========================================

    // One queued write, rw bit already stripped
    typedef struct packed {
        logic [6:0]  addr;
        logic [63:0] data;
    } cmd_entry_t;

    // SPI receiver FSM
    typedef enum logic [1:0] {
        SPI_IDLE    = 2'd0,
        SPI_SHIFT   = 2'd1,
        SPI_DISCARD = 2'd2
    } spi_state_e;

    // ========================================
    // Triangle setup
    // ========================================

    // Screen position, depth and RGB888 color
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [24:0] z;
        logic [23:0] color;
    } vertex_t;

    // Slot 0 in the low bits
    typedef struct packed {
        vertex_t [2:0] v;
    } triangle_t;

    // ========================================
    // Render settings
    // ========================================

    // Depth test function
    typedef enum logic [2:0] {
        Z_LESS     = 3'd0,
        Z_LEQUAL   = 3'd1,
        Z_EQUAL    = 3'd2,
        Z_GEQUAL   = 3'd3,
        Z_GREATER  = 3'd4,
        Z_NOTEQUAL = 3'd5,
        Z_ALWAYS   = 3'd6,
        Z_NEVER    = 3'd7
    } z_compare_e;

    typedef struct packed {
        logic       gouraud;
        logic       z_test;
        logic       z_write;
        logic       color_write;
        z_compare_e z_compare;
    } tri_mode_t;

    // fb_draw holds address bits 31:12 of the draw buffer
    typedef struct packed {
        tri_mode_t   mode;
        logic [15:0] z_range_min;
        logic [15:0] z_range_max;
        logic [19:0] fb_draw;
    } render_cfg_t;

endpackage

/* gpu_cmd_top.sv */
module gpu_cmd_top (
    input  logic                     clk_core,
    input  logic                     rst_n,
    input  logic                     spi_sck,
    input  logic                     spi_mosi,
    input  logic                     spi_cs_n,
    input  logic                     tri_ready,
    output logic                     gpio_cmd_full,
    output logic                     gpio_cmd_empty,
    output logic                     tri_valid,
    output gpu_cmd_pkg::triangle_t   tri_data,
    output gpu_cmd_pkg::render_cfg_t cfg
);

    import gpu_cmd_pkg::*;

    // Receiver to FIFO
    logic       push;
    cmd_entry_t push_entry;
    logic       fifo_full;

    // FIFO to register file
    logic       pop;
    cmd_entry_t head;

    // ========================================
    // SPI frame receiver
    // ========================================

    spi_cmd_receiver u_spi_rx (
        .clk_core   (clk_core),
        .rst_n      (rst_n),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_cs_n   (spi_cs_n),
        .full       (fifo_full),
        .push       (push),
        .push_entry (push_entry)
    );

    // ========================================
    // Command queue
    // ========================================

    // Near-full and empty go straight to the host GPIOs
    command_fifo u_cmd_fifo (
        .clk_core    (clk_core),
        .rst_n       (rst_n),
        .push        (push),
        .push_entry  (push_entry),
        .pop         (pop),
        .head        (head),
        .full        (fifo_full),
        .almost_full (gpio_cmd_full),
        .empty       (gpio_cmd_empty)
    );

    // ========================================
    // Register decode and triangle setup
    // ========================================

    register_file u_register_file (
        .clk_core  (clk_core),
        .rst_n     (rst_n),
        .empty     (gpio_cmd_empty),
        .head      (head),
        .pop       (pop),
        .tri_ready (tri_ready),
        .tri_valid (tri_valid),
        .tri_data  (tri_data),
        .cfg       (cfg)
    );

endmodule

/* register_file.sv */
`include "gpu_cmd_params.svh"

module register_file (
    input  logic                     clk_core,
    input  logic                     rst_n,
    input  logic                     empty,
    input  gpu_cmd_pkg::cmd_entry_t  head,
    output logic                     pop,
    input  logic                     tri_ready,
    output logic                     tri_valid,
    output gpu_cmd_pkg::triangle_t   tri_data,
    output gpu_cmd_pkg::render_cfg_t cfg
);

    import gpu_cmd_pkg::*;

    logic        stalled;
    logic        is_vertex;
    logic        is_kick;
    logic [23:0] cur_color;
    logic [1:0]  vtx_idx;
    vertex_t     new_vtx;

    // ========================================
    // Command pop
    // ========================================

    // Finished triangle not yet taken by the rasterizer
    assign stalled = tri_valid && !tri_ready;

    // One entry per cycle until the queue runs dry
    assign pop = !empty && !stalled;

    assign is_vertex = (head.addr == `GPU_REG_VERTEX_NOKICK)
                    || (head.addr == `GPU_REG_VERTEX_KICK);
    assign is_kick   = (head.addr == `GPU_REG_VERTEX_KICK);

    // Vertex fields from the data word
    always_comb begin
        new_vtx.x     = head.data[15:0];
        new_vtx.y     = head.data[31:16];
        new_vtx.z     = head.data[56:32];
        // Flat color latched by the last COLOR write
        new_vtx.color = cur_color;
    end

    // ========================================
    // Configuration registers
    // ========================================

    always_ff @(posedge clk_core) begin
        if (!rst_n) begin
            cfg       <= '0;
            cur_color <= '0;
            vtx_idx   <= '0;
            tri_valid <= 1'b0;
        end else begin
            // Handshake done
            if (tri_valid && tri_ready) begin
                tri_valid <= 1'b0;
            end
            if (pop) begin
                case (head.addr)
                    `GPU_REG_COLOR: begin
                        cur_color <= head.data[23:0];
                    end
                    `GPU_REG_TRI_MODE: begin
                        // Bit 1 reserved
                        cfg.mode.gouraud     <= head.data[0];
                        cfg.mode.z_test      <= head.data[2];
                        cfg.mode.z_write     <= head.data[3];
                        cfg.mode.color_write <= head.data[4];
                        cfg.mode.z_compare   <= z_compare_e'(head.data[7:5]);
                    end
                    `GPU_REG_Z_RANGE: begin
                        cfg.z_range_min <= head.data[15:0];
                        cfg.z_range_max <= head.data[31:16];
                    end
                    `GPU_REG_FB_DRAW: begin
                        // 4 KiB aligned base
                        cfg.fb_draw <= head.data[31:12];
                    end
                    `GPU_REG_VERTEX_NOKICK, `GPU_REG_VERTEX_KICK: begin
                        // Slot order 0, 1, 2, back to 0
                        vtx_idx <= (vtx_idx == 2'd2) ? 2'd0 : vtx_idx + 2'd1;
                        // Only a kick into the last slot completes a triangle
                        if (is_kick && vtx_idx == 2'd2) begin
                            tri_valid <= 1'b1;
                        end
                    end
                    default: begin
                        // Unmapped, dropped
                    end
                endcase
            end
        end
    end

    // ========================================
    // Vertex slots
    // ========================================

    // Frozen while stalled since pop is low
    always_ff @(posedge clk_core) begin
        if (pop && is_vertex) begin
            tri_data.v[vtx_idx] <= new_vtx;
        end
    end

    // Valid/ready hold across cycles
    a_tri_hold: assert property (
        @(posedge clk_core) disable iff (!rst_n)
        (tri_valid && !tri_ready) |=> (tri_valid && $stable(tri_data))
    ) else $error("triangle changed or dropped while stalled");

endmodule

/* spi_cmd_receiver.sv */
`include "gpu_cmd_params.svh"

module spi_cmd_receiver (
    input  logic                    clk_core,
    input  logic                    rst_n,
    input  logic                    spi_sck,
    input  logic                    spi_mosi,
    input  logic                    spi_cs_n,
    input  logic                    full,
    output logic                    push,
    output gpu_cmd_pkg::cmd_entry_t push_entry
);

    import gpu_cmd_pkg::*;

    localparam int FRAME_BITS = `GPU_FRAME_BITS;
    // Room to count one bit past a full frame
    localparam int CNT_W = $clog2(FRAME_BITS + 2);

    logic [1:0]            sck_sync;
    logic [1:0]            mosi_sync;
    logic [1:0]            cs_sync;
    logic                  sck_prev;
    logic                  cs_prev;
    logic                  sck_rise;
    logic                  cs_fall;
    logic                  cs_rise;
    spi_state_e            state;
    logic [CNT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] shift_reg;
    logic                  frame_ok;

    // ========================================
    // Pin synchronizers
    // ========================================

    // Two flops per pin, one more on sck and cs_n for edges
    always_ff @(posedge clk_core) begin
        if (!rst_n) begin
            sck_sync  <= 2'b00;
            mosi_sync <= 2'b00;
            cs_sync   <= 2'b11;
            sck_prev  <= 1'b0;
            cs_prev   <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            cs_sync   <= {cs_sync[0], spi_cs_n};
            sck_prev  <= sck_sync[1];
            cs_prev   <= cs_sync[1];
        end
    end

    // Mode 0, sample on rising sck
    assign sck_rise = sck_sync[1] && !sck_prev;
    assign cs_fall  = !cs_sync[1] && cs_prev;
    assign cs_rise  = cs_sync[1] && !cs_prev;

    // ========================================
    // Frame FSM
    // ========================================

    // Exact length, write frame, room in the FIFO
    assign frame_ok = (bit_cnt == CNT_W'(FRAME_BITS))
                   && !shift_reg[FRAME_BITS-1]
                   && !full;

    always_ff @(posedge clk_core) begin
        if (!rst_n) begin
            state   <= SPI_IDLE;
            bit_cnt <= '0;
            push    <= 1'b0;
        end else begin
            // Single-cycle strobe
            push <= 1'b0;
            case (state)
                SPI_IDLE: begin
                    if (cs_fall) begin
                        state   <= SPI_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                SPI_SHIFT: begin
                    if (cs_rise) begin
                        push  <= frame_ok;
                        state <= SPI_IDLE;
                    end else if (sck_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        // Bit 73 arriving, frame too long
                        if (bit_cnt == CNT_W'(FRAME_BITS)) begin
                            state <= SPI_DISCARD;
                        end
                    end
                end
                SPI_DISCARD: begin
                    // Swallow the rest until deselect
                    if (cs_rise) begin
                        state <= SPI_IDLE;
                    end
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // Payload shift, MSB first
    always_ff @(posedge clk_core) begin
        if (state == SPI_SHIFT && sck_rise && !cs_rise) begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], mosi_sync[1]};
        end
    end

    // Held stable in SPI_IDLE while push is out
    assign push_entry = shift_reg[FRAME_BITS-2:0];

    // Overflow is dropped here, never pushed
    a_no_push_when_full: assert property (
        @(posedge clk_core) disable iff (!rst_n) !(push && full)
    ) else $error("push while command FIFO full");

endmodule

/* tb_gpu_cmd_top.sv */
`include "gpu_cmd_params.svh"

module tb_gpu_cmd_top;

    import gpu_cmd_pkg::*;

    // 58 frames in total over all tests
    localparam int NUM_FRAMES   = 58;
    localparam int CYCLE_BUDGET = NUM_FRAMES * `GPU_FRAME_BITS * 8 + 4000;
    localparam int TIMEOUT      = 2 * CYCLE_BUDGET;

    logic        clk_core;
    logic        rst_n;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_cs_n;
    logic        tri_ready;
    logic        gpio_cmd_full;
    logic        gpio_cmd_empty;
    logic        tri_valid;
    triangle_t   tri_data;
    render_cfg_t cfg;

    // Reference model state
    render_cfg_t exp_cfg;
    triangle_t   exp_tri;
    logic [23:0] exp_color;
    logic [1:0]  exp_vidx;
    int          exp_tri_count;
    int          tri_count;
    logic [31:0] rng_state;
    int          cycle_count;

    // Check strobes, one cycle wide
    logic check_reset;
    logic check_state;
    logic check_full;
    logic reject_window;

    gpu_cmd_top gpu_cmd_top_inst (
        .clk_core       (clk_core),
        .rst_n          (rst_n),
        .spi_sck        (spi_sck),
        .spi_mosi       (spi_mosi),
        .spi_cs_n       (spi_cs_n),
        .tri_ready      (tri_ready),
        .gpio_cmd_full  (gpio_cmd_full),
        .gpio_cmd_empty (gpio_cmd_empty),
        .tri_valid      (tri_valid),
        .tri_data       (tri_data),
        .cfg            (cfg)
    );

    initial begin
        clk_core = 1'b0;
        forever #50 clk_core = ~clk_core;
    end

    // ========================================
    // Failure reporting
    // ========================================

    task automatic report_mismatch(input string name, input logic [255:0] exp_v,
                                   input logic [255:0] act_v);
        $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
        $display("Finished with errors");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("Failure at t=%0t: %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "run aborted");
    endtask

    // ========================================
    // Checks
    // ========================================

    a_reset_state: assert property (@(posedge clk_core) check_reset |->
        (!tri_valid && !gpio_cmd_full && gpio_cmd_empty && cfg == '0))
    else report_mismatch("tri_valid/gpio_cmd_full/gpio_cmd_empty/cfg", {3'b001, 59'd0},
        {$sampled(tri_valid), $sampled(gpio_cmd_full), $sampled(gpio_cmd_empty),
         $sampled(cfg)});

    a_cfg_match: assert property (@(posedge clk_core) check_state |-> cfg == exp_cfg)
    else report_mismatch("cfg", $sampled(exp_cfg), $sampled(cfg));

    a_tri_count: assert property (@(posedge clk_core)
        check_state |-> tri_count == exp_tri_count)
    else report_mismatch("tri_valid count", $sampled(exp_tri_count), $sampled(tri_count));

    // Any triangle shown must match the model
    a_tri_data: assert property (@(posedge clk_core) disable iff (!rst_n)
        tri_valid |-> tri_data == exp_tri)
    else report_mismatch("tri_data", $sampled(exp_tri), $sampled(tri_data));

    a_tri_hold: assert property (@(posedge clk_core) disable iff (!rst_n)
        (tri_valid && !tri_ready) |=> tri_valid)
    else report_failure("tri_valid dropped before tri_ready was high");

    a_full_raised: assert property (@(posedge clk_core) check_full |-> gpio_cmd_full)
    else report_mismatch("gpio_cmd_full", 1'b1, $sampled(gpio_cmd_full));

    // Bad frames must never reach the FIFO
    a_reject_empty: assert property (@(posedge clk_core) reject_window |-> gpio_cmd_empty)
    else report_mismatch("gpio_cmd_empty", 1'b1, $sampled(gpio_cmd_empty));

    // Accepted triangles
    always @(posedge clk_core) begin
        if (rst_n && tri_valid && tri_ready) begin
            tri_count <= tri_count + 1;
        end
    end

    always @(posedge clk_core) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: run exceeded %0d clock cycles", TIMEOUT);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    // ========================================
    // Stimulus helpers
    // ========================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    task automatic get_rand64(output logic [63:0] v);
        rng_state = xorshift32(rng_state);
        v[63:32] = rng_state;
        rng_state = xorshift32(rng_state);
        v[31:0] = rng_state;
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk_core);
    endtask

    // Register-map rules, applied as the host sends
    task automatic update_model(input logic [6:0] addr, input logic [63:0] d);
        case (addr)
            `GPU_REG_COLOR: exp_color = d[23:0];
            `GPU_REG_TRI_MODE: begin
                exp_cfg.mode.gouraud     = d[0];
                exp_cfg.mode.z_test      = d[2];
                exp_cfg.mode.z_write     = d[3];
                exp_cfg.mode.color_write = d[4];
                exp_cfg.mode.z_compare   = z_compare_e'(d[7:5]);
            end
            `GPU_REG_Z_RANGE: begin
                exp_cfg.z_range_min = d[15:0];
                exp_cfg.z_range_max = d[31:16];
            end
            `GPU_REG_FB_DRAW: exp_cfg.fb_draw = d[31:12];
            `GPU_REG_VERTEX_NOKICK, `GPU_REG_VERTEX_KICK: begin
                exp_tri.v[exp_vidx].x     = d[15:0];
                exp_tri.v[exp_vidx].y     = d[31:16];
                exp_tri.v[exp_vidx].z     = d[56:32];
                exp_tri.v[exp_vidx].color = exp_color;
                if (addr == `GPU_REG_VERTEX_KICK && exp_vidx == 2'd2) begin
                    exp_tri_count++;
                end
                exp_vidx = (exp_vidx == 2'd2) ? 2'd0 : exp_vidx + 2'd1;
            end
            default: ;
        endcase
    endtask

    // Mode 0, MSB first, half-period of 4 clocks
    task automatic shift_frame(input logic [72:0] bits, input int nbits);
        spi_cs_n <= 1'b0;
        wait_clocks(4);
        for (int i = 0; i < nbits; i++) begin
            spi_mosi <= bits[72-i];
            wait_clocks(4);
            spi_sck <= 1'b1;
            wait_clocks(4);
            spi_sck <= 1'b0;
        end
        wait_clocks(4);
        spi_cs_n <= 1'b1;
        // Covers synchronizer and push latency
        wait_clocks(10);
    endtask

    task automatic send_write(input logic [6:0] addr, input logic [63:0] data);
        update_model(addr, data);
        shift_frame({1'b0, addr, data, 1'b0}, `GPU_FRAME_BITS);
    endtask

    task automatic send_random(input logic [6:0] addr);
        logic [63:0] d;
        get_rand64(d);
        send_write(addr, d);
    endtask

    // Drain, then compare cfg and triangle count
    task automatic drain_and_check();
        while (!gpio_cmd_empty) @(posedge clk_core);
        @(posedge clk_core);
        check_state <= 1'b1;
        @(posedge clk_core);
        check_state <= 1'b0;
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        logic [63:0] d;
        logic [6:0]  addr;
        rst_n     = 1'b0;
        spi_sck   = 1'b0;
        spi_mosi  = 1'b0;
        spi_cs_n  = 1'b1;
        tri_ready = 1'b0;
        check_reset   = 1'b0;
        check_state   = 1'b0;
        check_full    = 1'b0;
        reject_window = 1'b0;
        exp_cfg       = '0;
        exp_tri       = '0;
        exp_color     = '0;
        exp_vidx      = '0;
        exp_tri_count = 0;
        tri_count     = 0;
        cycle_count   = 0;
        rng_state     = 32'd76007;
        wait_clocks(16);
        rst_n <= 1'b1;
        wait_clocks(2);
        // Reset values
        check_reset <= 1'b1;
        wait_clocks(1);
        check_reset <= 1'b0;
        tri_ready   <= 1'b1;
        // Random config writes, unmapped ones ignored
        for (int k = 0; k < 3; k++) begin
            send_random(`GPU_REG_TRI_MODE);
            send_random(`GPU_REG_Z_RANGE);
            send_random(`GPU_REG_FB_DRAW);
            drain_and_check();
        end
        send_random(7'h01);
        send_random(7'h7F);
        drain_and_check();
        // Flat color per vertex, one kick
        send_random(`GPU_REG_COLOR);
        send_random(`GPU_REG_VERTEX_NOKICK);
        send_random(`GPU_REG_COLOR);
        send_random(`GPU_REG_VERTEX_NOKICK);
        send_random(`GPU_REG_COLOR);
        send_random(`GPU_REG_VERTEX_KICK);
        drain_and_check();
        // Kick at slot 1 is not a triangle
        send_random(`GPU_REG_VERTEX_NOKICK);
        send_random(`GPU_REG_VERTEX_KICK);
        send_random(`GPU_REG_VERTEX_NOKICK);
        drain_and_check();
        // Back-pressure, stalled triangle then 31 queued frames
        tri_ready <= 1'b0;
        send_random(`GPU_REG_COLOR);
        send_random(`GPU_REG_VERTEX_NOKICK);
        send_random(`GPU_REG_VERTEX_NOKICK);
        send_random(`GPU_REG_VERTEX_KICK);
        for (int k = 0; k < 31; k++) begin
            get_rand64(d);
            case (d[1:0])
                2'd0:    addr = `GPU_REG_TRI_MODE;
                2'd1:    addr = `GPU_REG_Z_RANGE;
                2'd2:    addr = `GPU_REG_FB_DRAW;
                default: addr = 7'h12;
            endcase
            if (k == 30) begin
                check_full <= 1'b1;
                wait_clocks(1);
                check_full <= 1'b0;
            end
            send_write(addr, d);
        end
        tri_ready <= 1'b1;
        drain_and_check();
        // Read, short and long frames
        reject_window <= 1'b1;
        get_rand64(d);
        shift_frame({1'b1, `GPU_REG_FB_DRAW, d, 1'b0}, `GPU_FRAME_BITS);
        get_rand64(d);
        shift_frame({1'b0, `GPU_REG_Z_RANGE, d, 1'b0}, `GPU_FRAME_BITS - 1);
        get_rand64(d);
        shift_frame({1'b0, `GPU_REG_TRI_MODE, d, 1'b1}, `GPU_FRAME_BITS + 1);
        wait_clocks(8);
        reject_window <= 1'b0;
        drain_and_check();
        wait_clocks(4);
        $display("Finished with no errors");
        $finish;
    end

endmodule
